/* cache_geom_pkg.sv */
// address and data geometry shared by every cache block
// a request address splits as {tag, index, word select, byte offset}
// the index width depends on the set count and is derived in each module
package cache_geom_pkg;

	// width of one data or address word
	localparam int word_bits = 32;

	// one data word, also used for byte addresses
	typedef logic [word_bits-1:0] word_t;

	// byte offset inside a word, always zero on this bus
	localparam int word_off_bits = 2;

	// selects one word inside a block
	localparam int blk_off_bits = 1;

	// words held by one block
	localparam int block_words = 1 << blk_off_bits;

	// block offset width in bytes, handy for address math
	localparam int line_off_bits = blk_off_bits + word_off_bits;

endpackage

/* cache_ctrl_pkg.sv */
// types private to the cache controller and its storage
package cache_ctrl_pkg;

	// controller states
	// idle    serves hits and starts misses or the flush
	// wbN     victim writeback, word 0 then word 1
	// fetchN  block fill, word 0 then word 1
	// flushN  way 0 word 0/1, then way 1 word 0/1, of one set
	// done    flush finished, holds until reset
	typedef enum logic [3:0] {
		idle,
		fetch1,
		fetch2,
		wb1,
		wb2,
		flush1,
		flush2,
		flush3,
		flush4,
		done
	} ctrl_state_t;

	// picks one of the two ways
	typedef logic way_t;

endpackage

/* dcache_array.sv */
// two-way storage: tags, data, valid, dirty and one LRU bit per set
// hit compare on the request address, victim and flush read ports
module dcache_array #(
	parameter int NUM_SETS = 8,
	localparam int idx_bits = $clog2(NUM_SETS),
	localparam int tag_bits = cache_geom_pkg::word_bits - idx_bits
		- cache_geom_pkg::line_off_bits
) (
	input logic CLK,
	input logic nRST,
	input cache_geom_pkg::word_t dmemaddr, // request address from the core
	input logic wr_en, // write the target way this edge
	input logic [cache_geom_pkg::blk_off_bits-1:0] wr_word,
	input cache_geom_pkg::word_t wr_data,
	input logic wr_valid,
	input logic wr_dirty,
	input logic lru_touch, // mark hit way as most recently used
	input logic clear, // drop every line and LRU bit
	input logic [idx_bits-1:0] flush_idx,
	input cache_ctrl_pkg::way_t flush_way,
	output logic hit, // raw: tag match and valid only
	output cache_geom_pkg::word_t hit_word,
	output logic [tag_bits-1:0] victim_tag,
	output logic victim_valid,
	output logic victim_dirty,
	output cache_geom_pkg::word_t victim_word0,
	output cache_geom_pkg::word_t victim_word1,
	output logic [tag_bits-1:0] flush_tag,
	output logic flush_dirty,
	output cache_geom_pkg::word_t flush_word0,
	output cache_geom_pkg::word_t flush_word1
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	// line storage, tags and data carry no reset
	logic [tag_bits-1:0] tags [2][NUM_SETS];
	word_t data [2][NUM_SETS][block_words];
	logic [NUM_SETS-1:0] valid [2];
	logic [NUM_SETS-1:0] dirty [2];
	logic [NUM_SETS-1:0] lru; // way to evict next in each set

	// request address fields
	logic [tag_bits-1:0] req_tag;
	logic [idx_bits-1:0] req_idx;
	logic [blk_off_bits-1:0] req_word;

	logic [1:0] match; // per-way tag hit
	way_t hit_way;
	way_t victim_way;
	way_t tgt_way; // way written on wr_en

	assign req_tag = dmemaddr[word_bits-1 -: tag_bits];
	assign req_idx = dmemaddr[line_off_bits +: idx_bits];
	assign req_word = dmemaddr[word_off_bits +: blk_off_bits];

	// both ways compared in parallel
	assign match[0] = valid[0][req_idx] && (tags[0][req_idx] == req_tag);
	assign match[1] = valid[1][req_idx] && (tags[1][req_idx] == req_tag);
	assign hit = |match;
	assign hit_way = match[1]; // way 0 unless way 1 matched

	// hit way while it hits, otherwise the LRU way gets filled
	assign victim_way = lru[req_idx];
	assign tgt_way = hit ? hit_way : victim_way;

	// load data, meaningful only while hit is high
	assign hit_word = data[hit_way][req_idx][req_word];

	// victim line read out for writeback
	assign victim_tag = tags[victim_way][req_idx];
	assign victim_valid = valid[victim_way][req_idx];
	assign victim_dirty = dirty[victim_way][req_idx];
	assign victim_word0 = data[victim_way][req_idx][0];
	assign victim_word1 = data[victim_way][req_idx][1];

	// flush port, addressed by the controller counter
	assign flush_tag = tags[flush_way][flush_idx];
	assign flush_dirty = valid[flush_way][flush_idx] && dirty[flush_way][flush_idx];
	assign flush_word0 = data[flush_way][flush_idx][0];
	assign flush_word1 = data[flush_way][flush_idx][1];

	// line state and LRU bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '{default: '0};
			dirty <= '{default: '0};
			lru <= '0;
		end else if (clear) begin
			// end of flush, everything back to empty
			valid <= '{default: '0};
			dirty <= '{default: '0};
			lru <= '0;
		end else begin
			if (wr_en) begin
				valid[tgt_way][req_idx] <= wr_valid;
				dirty[tgt_way][req_idx] <= wr_dirty;
			end
			if (lru_touch) begin
				lru[req_idx] <= ~hit_way; // the other way is now oldest
			end
		end
	end

	// tag and one data word per write
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			tags[tgt_way][req_idx] <= req_tag;
			data[tgt_way][req_idx][wr_word] <= wr_data;
		end
	end

endmodule

/* dcache_ctrl.sv */
// cache controller FSM
// serves hits in idle, runs writeback and fill on a miss,
// walks every set on halt and writes the dirty words back
module dcache_ctrl #(
	parameter int NUM_SETS = 8,
	localparam int idx_bits = $clog2(NUM_SETS),
	localparam int tag_bits = cache_geom_pkg::word_bits - idx_bits
		- cache_geom_pkg::line_off_bits
) (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input cache_geom_pkg::word_t dmemaddr,
	input cache_geom_pkg::word_t dmemstore,
	input logic halt,
	input logic hit,
	input cache_geom_pkg::word_t hit_word,
	input logic [tag_bits-1:0] victim_tag,
	input logic victim_valid,
	input logic victim_dirty,
	input cache_geom_pkg::word_t victim_word0,
	input cache_geom_pkg::word_t victim_word1,
	input logic [tag_bits-1:0] flush_tag,
	input logic flush_dirty,
	input cache_geom_pkg::word_t flush_word0,
	input cache_geom_pkg::word_t flush_word1,
	input logic dwait,
	input cache_geom_pkg::word_t dload,
	output logic dhit,
	output cache_geom_pkg::word_t dmemload,
	output logic flushing,
	output logic flushed,
	output logic dREN,
	output logic dWEN,
	output cache_geom_pkg::word_t daddr,
	output cache_geom_pkg::word_t dstore,
	output logic wr_en,
	output logic [cache_geom_pkg::blk_off_bits-1:0] wr_word,
	output cache_geom_pkg::word_t wr_data,
	output logic wr_valid,
	output logic wr_dirty,
	output logic lru_touch,
	output logic clear,
	output logic [idx_bits-1:0] flush_idx,
	output cache_ctrl_pkg::way_t flush_way
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	ctrl_state_t state, next_state;

	// request address fields
	logic [tag_bits-1:0] req_tag;
	logic [idx_bits-1:0] req_idx;
	logic [blk_off_bits-1:0] req_word;

	logic req; // core wants a load or a store
	logic req_hit; // request served this cycle
	logic flush_step; // current flush word done, stored or skipped
	logic last_set;
	logic flush_inc; // advance flush_idx at the edge

	// byte address of one word of a block
	function automatic word_t blk_addr(
		input logic [tag_bits-1:0] tag,
		input logic [idx_bits-1:0] idx,
		input logic [blk_off_bits-1:0] wsel
	);
		return {tag, idx, wsel, {word_off_bits{1'b0}}};
	endfunction

	assign req_tag = dmemaddr[word_bits-1 -: tag_bits];
	assign req_idx = dmemaddr[line_off_bits +: idx_bits];
	assign req_word = dmemaddr[word_off_bits +: blk_off_bits];

	assign req = dmemREN || dmemWEN;

	// halt wins over any request in the same cycle
	assign req_hit = (state == idle) && !halt && req && hit;
	assign dhit = req_hit;
	assign dmemload = hit_word; // array already picked the hit way
	assign lru_touch = req_hit; // loads and stores both count as use

	// flush status seen by the core
	assign flushing = ((state == idle) && halt)
		|| (state inside {flush1, flush2, flush3, flush4});
	assign flushed = (state == done);
	assign clear = (state == done); // tables wiped while parked in done

	// flush1/2 read way 0, flush3/4 read way 1
	assign flush_way = way_t'((state == flush3) || (state == flush4));

	// clean lines are skipped in one cycle each
	assign flush_step = !dwait || !flush_dirty;
	assign last_set = (flush_idx == idx_bits'(NUM_SETS - 1));

	// next state
	always_comb begin
		next_state = state;
		flush_inc = 1'b0;
		case (state)
			idle: begin
				if (halt) begin
					next_state = flush1;
				end else if (req && !hit) begin
					// dirty victim goes out before the fill
					if (victim_valid && victim_dirty) begin
						next_state = wb1;
					end else begin
						next_state = fetch1;
					end
				end
			end
			wb1: if (!dwait) next_state = wb2;
			wb2: if (!dwait) next_state = fetch1;
			fetch1: if (!dwait) next_state = fetch2;
			fetch2: if (!dwait) next_state = idle; // request hits next cycle
			flush1: if (flush_step) next_state = flush2;
			flush2: if (flush_step) next_state = flush3;
			flush3: if (flush_step) next_state = flush4;
			flush4: begin
				if (flush_step) begin
					flush_inc = 1'b1;
					next_state = last_set ? done : flush1;
				end
			end
			done: next_state = done; // only reset leaves
			default: next_state = idle;
		endcase
	end

	// memory side and array write port
	always_comb begin
		dREN = 1'b0;
		dWEN = 1'b0;
		daddr = '0;
		dstore = '0;
		wr_en = 1'b0;
		wr_word = req_word;
		wr_data = dmemstore;
		wr_valid = 1'b1;
		wr_dirty = 1'b0;
		case (state)
			idle: begin
				// write hit, line becomes dirty
				if (req_hit && dmemWEN) begin
					wr_en = 1'b1;
					wr_dirty = 1'b1;
				end
			end
			wb1: begin
				dWEN = 1'b1;
				daddr = blk_addr(victim_tag, req_idx, blk_off_bits'(0));
				dstore = victim_word0;
			end
			wb2: begin
				dWEN = 1'b1;
				daddr = blk_addr(victim_tag, req_idx, blk_off_bits'(1));
				dstore = victim_word1;
			end
			fetch1: begin
				dREN = 1'b1;
				daddr = blk_addr(req_tag, req_idx, blk_off_bits'(0));
				// new tag goes in now, line stays invalid until word 1
				wr_en = 1'b1;
				wr_word = blk_off_bits'(0);
				wr_data = dload;
				wr_valid = 1'b0;
			end
			fetch2: begin
				dREN = 1'b1;
				daddr = blk_addr(req_tag, req_idx, blk_off_bits'(1));
				wr_en = 1'b1;
				wr_word = blk_off_bits'(1);
				wr_data = dload;
				wr_valid = !dwait; // valid only with the last word in hand
			end
			flush1, flush3: begin
				dWEN = flush_dirty; // clean lines never reach memory
				daddr = blk_addr(flush_tag, flush_idx, blk_off_bits'(0));
				dstore = flush_word0;
			end
			flush2, flush4: begin
				dWEN = flush_dirty;
				daddr = blk_addr(flush_tag, flush_idx, blk_off_bits'(1));
				dstore = flush_word1;
			end
			default: begin
			end
		endcase
	end

	// state register
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// flush set counter, steps once per finished set
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			flush_idx <= '0;
		end else if (flush_inc) begin
			flush_idx <= flush_idx + 1'b1;
		end
	end

endmodule

/* dcache_top.sv */
// two-way write-back data cache
// core side: level requests answered by dhit
// memory side: dREN/dWEN levels held while dwait is high
module dcache_top #(
	parameter int NUM_SETS = 8 // power of two, two or more
) (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input cache_geom_pkg::word_t dmemaddr,
	input cache_geom_pkg::word_t dmemstore,
	input logic halt,
	output logic dhit,
	output cache_geom_pkg::word_t dmemload,
	output logic flushing,
	output logic flushed,
	output logic dREN,
	output logic dWEN,
	output cache_geom_pkg::word_t daddr,
	output cache_geom_pkg::word_t dstore,
	input logic dwait,
	input cache_geom_pkg::word_t dload
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int idx_bits = $clog2(NUM_SETS);
	localparam int tag_bits = word_bits - idx_bits - line_off_bits;

	// controller to array
	logic wr_en;
	logic [blk_off_bits-1:0] wr_word;
	word_t wr_data;
	logic wr_valid;
	logic wr_dirty;
	logic lru_touch;
	logic clear;
	logic [idx_bits-1:0] flush_idx;
	way_t flush_way;

	// array to controller
	logic hit;
	word_t hit_word;
	logic [tag_bits-1:0] victim_tag;
	logic victim_valid;
	logic victim_dirty;
	word_t victim_word0;
	word_t victim_word1;
	logic [tag_bits-1:0] flush_tag;
	logic flush_dirty;
	word_t flush_word0;
	word_t flush_word1;

	// all port names match the nets above
	dcache_array #(
		.NUM_SETS(NUM_SETS)
	) u_array (.*);

	dcache_ctrl #(
		.NUM_SETS(NUM_SETS)
	) u_ctrl (.*);

endmodule

/* tb_clock_gen.sv */
// free running testbench clock, starts low
module tb_clock_gen #(
	parameter int period = 40 // ns
) (
	output logic CLK
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK;
	end

endmodule

/* tb_dcache.sv */
// testbench for the two-way write-back data cache
// core requests and memory answers change on the falling edge
module tb_dcache;
	timeunit 1ns;
	timeprecision 100ps;
	import cache_geom_pkg::*;

	localparam int num_sets = 8;
	localparam int period = 40;
	localparam int quarter = period / 4; // sample point after a falling edge
	localparam word_t seed = 32'hd0bd_afe4;
	localparam int max_stall = 3; // longest dwait run per memory word
	localparam word_t tag_stride = word_t'(num_sets * 8); // next tag, same set
	localparam int n_directed = 16;
	localparam int n_random = 200;
	// worst access: writeback and fill, every word stalled, plus the hit
	localparam int op_cycles = 4 * (max_stall + 1) + 4;
	localparam int flush_cycles = num_sets * 4 * (max_stall + 1) + 8;
	localparam int watchdog_ns =
		(8 + (n_directed + n_random) * op_cycles + flush_cycles) * period;

	logic CLK, nRST, dmemREN, dmemWEN, halt, dwait;
	logic dhit, flushing, flushed, dREN, dWEN;
	word_t dmemaddr, dmemstore, dmemload, daddr, dstore, dload;

	word_t mem [word_t]; // memory model contents, fill pattern elsewhere
	word_t ref_mem [word_t]; // last value stored to each word by the core
	word_t rd_log [$]; // addresses read from memory
	int rd_count, wr_count; // memory words served

	string cur_test;
	int test_errors, errors, tests_run, tests_failed;
	word_t chk_addr, chk_data;
	event load_done;

	tb_clock_gen #(.period(period)) u_clk (.CLK(CLK));

	dcache_top #(.NUM_SETS(num_sets)) uut (.*);

	function automatic word_t lcg_next(input word_t s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// untouched memory, every address bit changes the word
	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic word_t mem_read(input word_t addr);
		return mem.exists(addr) ? mem[addr] : fill_word(addr);
	endfunction

	// what a load from addr has to return
	function automatic word_t ref_load(input word_t addr);
		if (ref_mem.exists(addr)) return ref_mem[addr];
		return fill_word(addr);
	endfunction

	task automatic check_value(input word_t addr, input word_t exp, input word_t act);
		assert (act == exp) else begin
			$display("error %s: addr %h expected %h actual %h", cur_test, addr, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_cond(input bit ok, input string what);
		assert (ok) else begin
			$display("%s: %s", cur_test, what);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0) $display("test %-10s ok", cur_test);
		else begin
			$display("test %-10s %0d errors", cur_test, test_errors);
			tests_failed++;
		end
	endtask

	// one core request, called and left at a falling edge
	task automatic access(input bit is_wr, input word_t addr, input word_t wdata,
		output int cycles);
		cycles = 0;
		dmemREN = !is_wr;
		dmemWEN = is_wr;
		dmemaddr = addr;
		dmemstore = wdata;
		#(quarter);
		while (!dhit) begin // miss in progress
			@(negedge CLK);
			#(quarter);
			cycles++;
		end
		if (!is_wr) begin
			chk_addr = addr;
			chk_data = dmemload;
			-> load_done;
		end
		@(posedge CLK); // write hit lands here
		if (is_wr) ref_mem[addr] = wdata;
		@(negedge CLK);
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
	endtask

	// memory model, each word waits a random number of cycles
	initial begin
		word_t rng;
		int stall;
		bit busy;
		rng = seed;
		stall = 0;
		busy = 1'b0;
		dwait = 1'b1;
		dload = '0;
		forever begin
			@(negedge CLK);
			if (!(dREN || dWEN)) begin
				busy = 1'b0;
				dwait = 1'b1;
			end else begin
				if (!busy || !dwait) begin // new word, last one was taken
					rng = lcg_next(rng);
					stall = int'((rng >> 16) % (max_stall + 1));
					busy = 1'b1;
				end
				if (stall > 0) begin
					stall--;
					dwait = 1'b1;
				end else begin
					dwait = 1'b0;
					if (dWEN) begin
						mem[daddr] = dstore;
						wr_count++;
					end else begin
						dload = mem_read(daddr);
						rd_log.push_back(daddr);
						rd_count++;
					end
				end
			end
		end
	end

	// every load against the reference
	always @(load_done) check_value(chk_addr, ref_load(chk_addr), chk_data);

	initial begin
		#(watchdog_ns);
		$display("timeout: tests still running after %0d ns", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int c, r0, w0;
		word_t rng, addr, a, b, cc;
		bit is_wr, saw_flushing;
		nRST = 1'b0;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		dmemaddr = '0;
		dmemstore = '0;
		halt = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rd_count = 0;
		wr_count = 0;
		repeat (8) @(negedge CLK);
		nRST = 1'b1;

		start_test("reset");
		#(quarter);
		check_cond(!dREN && !dWEN && !flushing && !flushed, "outputs not idle after reset");
		@(negedge CLK);
		r0 = rd_count;
		access(1'b0, 32'h0000_0040, '0, c);
		check_cond(c > 0 && rd_count - r0 == 2, "first request hit without a fetch");
		end_test();

		start_test("read_fill");
		rd_log.delete();
		access(1'b0, 32'h0000_0104, '0, c);
		check_cond(rd_log.size() == 2, "cold read did not fetch two words");
		if (rd_log.size() == 2) begin
			check_value(32'h0000_0100, 32'h0000_0100, rd_log[0]);
			check_value(32'h0000_0104, 32'h0000_0104, rd_log[1]);
		end
		r0 = rd_count;
		access(1'b0, 32'h0000_0104, '0, c);
		check_cond(c == 0 && rd_count == r0, "repeated read went to memory");
		end_test();

		start_test("write_hit");
		r0 = rd_count;
		w0 = wr_count;
		access(1'b1, 32'h0000_0104, 32'hcafe_0001, c);
		access(1'b0, 32'h0000_0104, '0, c);
		access(1'b0, 32'h0000_0100, '0, c); // other word of the block
		check_cond(rd_count == r0 && wr_count == w0, "write hit touched memory");
		end_test();

		// A, B and C share set 2
		start_test("lru");
		a = 32'h0000_1010;
		b = a + tag_stride;
		cc = a + 2 * tag_stride;
		access(1'b0, a, '0, c);
		access(1'b1, b, 32'hbbbb_0002, c); // allocate, B now dirty
		access(1'b0, a, '0, c); // B is the oldest now
		w0 = wr_count;
		access(1'b0, cc, '0, c);
		check_cond(wr_count - w0 == 2, "dirty victim was not written back");
		check_value(b, 32'hbbbb_0002, mem_read(b));
		r0 = rd_count;
		access(1'b0, a, '0, c);
		check_cond(rd_count == r0, "recently used line was evicted");
		r0 = rd_count;
		access(1'b0, b, '0, c);
		check_cond(rd_count - r0 == 2, "evicted line still hit");
		end_test();

		start_test("random");
		rng = lcg_next(seed);
		for (int i = 0; i < n_random; i++) begin
			rng = lcg_next(rng);
			is_wr = rng[20];
			addr = 32'h0000_2000 + word_t'(rng[17:16]) * tag_stride
				+ word_t'(rng[19:18]) * 8 + word_t'(rng[21]) * 4;
			rng = lcg_next(rng);
			access(is_wr, addr, rng, c);
		end
		end_test();

		start_test("flush");
		access(1'b1, 32'h0000_0048, 32'hf00d_0003, c);
		access(1'b1, 32'h0000_0058, 32'hf00d_0004, c);
		access(1'b1, 32'h0000_1014, 32'hf00d_0005, c);
		access(1'b1, 32'h0000_007c, 32'hf00d_0006, c);
		w0 = wr_count;
		saw_flushing = 1'b0;
		halt = 1'b1;
		#(quarter);
		while (!flushed) begin
			if (flushing) saw_flushing = 1'b1;
			@(negedge CLK);
			#(quarter);
		end
		check_cond(saw_flushing, "flushing never went high");
		check_cond(wr_count > w0, "no dirty word was written back");
		check_cond(!dREN && !dWEN, "memory request still active after flushed");
		foreach (ref_mem[k]) check_value(k, ref_mem[k], mem_read(k));
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) $display("Verification passed");
		else $display("Verification failed");
		$finish;
	end

endmodule

/* flist.f */
cache_geom_pkg.sv
cache_ctrl_pkg.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -j 0 \
	--top-module tb_dcache -f flist.f \
	--Mdir obj_dir -o tb_dcache_sim

./obj_dir/tb_dcache_sim > sim.log 2>&1
cat sim.log

if grep -qx "Verification passed" sim.log; then
	exit 0
fi
exit 1
